//--- dac_path.f
+incdir+verilog
verilog/dac_pkg.sv
verilog/dac_cmd_sched.sv
verilog/dac_cmd_queue.sv
verilog/dac_sample_gen.sv
verilog/dac_batch_scale.sv
verilog/dac_path_top.sv
verif/tb_clk_gen.sv
verif/dac_path_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the DAC path testbench with Verilator, run it and check the result

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f dac_path.f \
	--top-module dac_path_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vdac_path_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "PASS: all tests" <<< "$sim_out"; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- verif/dac_path_tb.sv
`default_nettype none

`include "dac_defines.svh"

module dac_path_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import dac_pkg::*;

	localparam int NUM_TESTS = 9;
	localparam int GAP_LIMIT = 200;
	localparam int IDLE_LIMIT = 100;
	localparam int FIRST_BATCH_LIMIT = 8; // Request to first batch with dac_rdy_i high

	localparam logic [1:0] REQ_TRIG = 2'd0;
	localparam logic [1:0] REQ_RAND = 2'd1;
	localparam logic [1:0] REQ_BOTH = 2'd2; // Rand and trig queued together

	localparam logic [1:0] STALL_NONE = 2'd0;
	localparam logic [1:0] STALL_RAND = 2'd1;
	localparam logic [1:0] STALL_HOLD = 2'd2; // Low through the requests, then random

	typedef struct packed {
		logic [1:0] req;
		sample_t seed;
		scale_t scale;
		burst_t burst;
		logic [1:0] stall;
		logic [7:0] halt_after; // 0 means no halt
	} test_entry_t;

	logic ps_clk;
	logic ps_rst;
	logic halt;
	logic run_rand;
	logic run_trig;
	sample_t seed;
	scale_t scale;
	burst_t burst;
	logic dac_rdy;
	batch_t batch;
	logic batch_valid;
	logic sched_idle;

	test_entry_t test_table [NUM_TESTS];
	string test_names [NUM_TESTS];
	batch_t exp_q [$];
	int error_count;
	logic [31:0] rng_state;

	tb_clk_gen clk_gen_inst (.ps_clk_o(ps_clk), .ps_rst_o(ps_rst));

	dac_path_top dac_path_top_inst (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.halt_i(halt), .run_rand_i(run_rand), .run_trig_i(run_trig),
		.seed_i(seed), .scale_i(scale), .burst_i(burst), .dac_rdy_i(dac_rdy),
		.batch_o(batch), .batch_valid_o(batch_valid), .sched_idle_o(sched_idle)
	);

	// 32-bit Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] rng_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic rand_bit();
		rng_state = rng_step(rng_state);
		return rng_state[0];
	endfunction

	// Model of the sample LFSR, taps 16 14 13 11
	function automatic sample_t model_lfsr_next(input sample_t s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic add_trig_batches(input scale_t sc, input burst_t n);
		batch_t b;
		for (int i = 0; i < int'(n); i++) begin
			for (int k = 0; k < `BATCH_SIZE; k++) begin
				b[k*`SAMPLE_W +: `SAMPLE_W] = sample_t'(i * `BATCH_SIZE + k) >> sc;
			end
			exp_q.push_back(b);
		end
	endtask

	task automatic add_rand_batches(input sample_t sd, input scale_t sc, input burst_t n);
		batch_t b;
		sample_t st;
		st = (sd == '0) ? sample_t'(1) : sd;
		for (int i = 0; i < int'(n); i++) begin
			for (int k = 0; k < `BATCH_SIZE; k++) begin
				st = model_lfsr_next(st);
				b[k*`SAMPLE_W +: `SAMPLE_W] = st >> sc;
			end
			exp_q.push_back(b);
		end
	endtask

	task automatic init_table();
		test_table[0] = '{REQ_TRIG, 16'h0000, 4'd0, 8'd3, STALL_NONE, 8'd0};
		test_names[0] = "trig_ramp";
		test_table[1] = '{REQ_RAND, 16'hACE1, 4'd0, 8'd4, STALL_NONE, 8'd0};
		test_names[1] = "rand_seed_ace1";
		test_table[2] = '{REQ_RAND, 16'h0000, 4'd0, 8'd2, STALL_NONE, 8'd0};
		test_names[2] = "rand_seed_zero";
		test_table[3] = '{REQ_TRIG, 16'h0000, 4'd3, 8'd5, STALL_NONE, 8'd0};
		test_names[3] = "trig_new_scale_burst";
		test_table[4] = '{REQ_TRIG, 16'h0000, 4'd1, 8'd6, STALL_RAND, 8'd0};
		test_names[4] = "trig_stalled";
		test_table[5] = '{REQ_RAND, 16'h1234, 4'd2, 8'd5, STALL_RAND, 8'd0};
		test_names[5] = "rand_stalled";
		test_table[6] = '{REQ_TRIG, 16'h0000, 4'd0, 8'd40, STALL_NONE, 8'd2};
		test_names[6] = "trig_halted";
		test_table[7] = '{REQ_TRIG, 16'h0000, 4'd0, 8'd2, STALL_NONE, 8'd0};
		test_names[7] = "trig_after_halt";
		test_table[8] = '{REQ_BOTH, 16'h0F0F, 4'd1, 8'd3, STALL_HOLD, 8'd0};
		test_names[8] = "queued_requests";
	endtask

	task automatic wait_idle(input string name);
		int cyc;
		cyc = 0;
		@(negedge ps_clk);
		while (!sched_idle && cyc < IDLE_LIMIT) begin
			@(negedge ps_clk);
			cyc++;
		end
		if (!sched_idle) begin
			$display("Error in %s: sched_idle_o stayed low for %0d cycles", name, IDLE_LIMIT);
			error_count++;
		end
	endtask

	task automatic run_test(input int idx);
		test_entry_t e;
		string name;
		int cyc;
		int gap;
		int got;
		logic seen_busy;
		logic halt_sent;
		logic done;
		logic rdy_seen; // dac_rdy_i in the cycle before the current one
		e = test_table[idx];
		name = test_names[idx];

		// Scale first, then burst, each one settled as a config command
		@(posedge ps_clk);
		scale <= e.scale;
		wait_idle(name);
		@(posedge ps_clk);
		burst <= e.burst;
		seed <= e.seed;
		wait_idle(name);

		exp_q.delete();
		if (e.req == REQ_TRIG) begin
			add_trig_batches(e.scale, e.burst);
		end else if (e.req == REQ_RAND) begin
			add_rand_batches(e.seed, e.scale, e.burst);
		end else begin
			add_rand_batches(e.seed, e.scale, e.burst); // Rand wins over trig
			add_trig_batches(e.scale, e.burst);
		end

		@(posedge ps_clk);
		run_trig <= (e.req != REQ_RAND);
		run_rand <= (e.req != REQ_TRIG);
		dac_rdy <= (e.stall != STALL_HOLD);
		cyc = 0;
		gap = 0;
		got = 0;
		seen_busy = 1'b0;
		halt_sent = 1'b0;
		done = 1'b0;
		rdy_seen = (e.stall != STALL_HOLD);
		while (!done) begin
			@(posedge ps_clk);
			run_trig <= (e.req == REQ_BOTH) && (cyc == 0); // Repeat merges with pending
			run_rand <= 1'b0;
			halt <= 1'b0;
			if (e.halt_after != 0 && !halt_sent && got >= int'(e.halt_after)) begin
				halt <= 1'b1;
				halt_sent = 1'b1;
			end
			if (e.stall == STALL_NONE) begin
				dac_rdy <= 1'b1;
			end else if (e.stall == STALL_HOLD && cyc < 8) begin
				dac_rdy <= 1'b0;
			end else begin
				dac_rdy <= rand_bit();
			end
			@(negedge ps_clk);
			cyc++;
			gap++;
			if (batch_valid && !rdy_seen) begin
				$display("Error in %s: batch %0d was issued while dac_rdy_i was low",
					name, got);
				error_count++;
			end
			rdy_seen = dac_rdy;
			if (batch_valid) begin
				gap = 0;
				if (got == 0 && e.stall == STALL_NONE && cyc > FIRST_BATCH_LIMIT) begin
					$display("Fail %s first batch latency: expected at most %0d, actual %0d",
						name, FIRST_BATCH_LIMIT, cyc);
					error_count++;
				end
				if (got >= int'(exp_q.size())) begin
					$display("Error in %s: batch %0d arrived beyond the %0d expected",
						name, got, exp_q.size());
					error_count++;
				end else if (batch !== exp_q[got]) begin
					$display("Fail %s batch %0d: expected %h, actual %h",
						name, got, exp_q[got], batch);
					error_count++;
				end
				got++;
			end
			if (!sched_idle) begin
				seen_busy = 1'b1;
			end
			if (seen_busy && sched_idle) begin
				done = 1'b1;
			end else if (gap > GAP_LIMIT) begin
				$display("Error in %s: no batch and no idle for %0d cycles", name, GAP_LIMIT);
				error_count++;
				done = 1'b1;
			end
		end

		if (e.halt_after == 0) begin
			if (got != int'(exp_q.size())) begin
				$display("Fail %s batch count: expected %0d, actual %0d",
					name, exp_q.size(), got);
				error_count++;
			end
		end else if (got >= int'(exp_q.size()) || got < int'(e.halt_after)) begin
			$display("Fail %s batch count: expected %0d to %0d, actual %0d",
				name, e.halt_after, exp_q.size() - 1, got);
			error_count++;
		end

		@(posedge ps_clk);
		dac_rdy <= 1'b1;
		halt <= 1'b0;
		run_trig <= 1'b0;
	endtask

	initial begin
		int rst_cyc;
		error_count = 0;
		rng_state = 32'h212833c2;
		halt = 1'b0;
		run_rand = 1'b0;
		run_trig = 1'b0;
		seed = '0;
		scale = '0;
		burst = burst_t'(1);
		dac_rdy = 1'b1;
		init_table();

		rst_cyc = 0;
		while (ps_rst !== 1'b0 && rst_cyc < 20) begin
			@(posedge ps_clk);
			rst_cyc++;
		end
		if (ps_rst !== 1'b0) begin
			$display("Error: reset was never released");
			error_count++;
		end
		@(negedge ps_clk);
		if (batch_valid !== 1'b0 || sched_idle !== 1'b1) begin
			$display("Fail reset_state: expected valid 0 idle 1, actual valid %b idle %b",
				batch_valid, sched_idle);
			error_count++;
		end

		for (int i = 0; i < NUM_TESTS; i++) begin
			run_test(i);
		end

		$display("Tests run: %0d, errors: %0d", NUM_TESTS, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic ps_clk_o,
	output logic ps_rst_o
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;

	initial begin
		ps_clk_o = 1'b0;
		forever #5 ps_clk_o = ~ps_clk_o; // 10 ns period
	end

	initial begin
		ps_rst_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge ps_clk_o);
		ps_rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

//--- verilog/dac_batch_scale.sv
`default_nettype none

`include "dac_defines.svh"

module dac_batch_scale (
	input wire ps_clk,
	input wire ps_rst,
	input wire gen_valid_i,
	input wire dac_pkg::batch_word_t gen_word_i,
	output dac_pkg::batch_t batch_o,
	output logic batch_valid_o
);

	always_ff @(posedge ps_clk) begin
		if (gen_valid_i) begin
			// Logical shift per lane by the scale that came with the batch
			for (int k = 0; k < `BATCH_SIZE; k++) begin
				batch_o[k*`SAMPLE_W +: `SAMPLE_W] <=
					gen_word_i.data[k*`SAMPLE_W +: `SAMPLE_W] >> gen_word_i.scale;
			end
		end
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			batch_valid_o <= 1'b0;
		end else begin
			batch_valid_o <= gen_valid_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/dac_cmd_queue.sv
`default_nettype none

`include "dac_defines.svh"

module dac_cmd_queue (
	input wire ps_clk,
	input wire ps_rst,
	input wire push_i,
	input wire dac_pkg::dac_cmd_t cmd_i,
	input wire pop_i,
	output logic head_valid_o,
	output dac_pkg::dac_cmd_t head_o,
	output logic credit_ret_o
);
	import dac_pkg::*;

	localparam int PTR_W = $clog2(`CMDQ_DEPTH);

	dac_cmd_t mem [`CMDQ_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	credit_t count;
	logic do_pop;

	assign head_valid_o = (count != '0);
	assign head_o = mem[rd_ptr]; // Show-ahead
	assign do_pop = pop_i && head_valid_o;

	always_ff @(posedge ps_clk) begin
		if (push_i) begin
			mem[wr_ptr] <= cmd_i; // Credits guarantee a free slot
		end
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_ret_o <= 1'b0;
		end else begin
			if (push_i) begin
				wr_ptr <= (wr_ptr == PTR_W'(`CMDQ_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(`CMDQ_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + credit_t'(push_i) - credit_t'(do_pop);
			credit_ret_o <= do_pop; // One credit back per freed entry
		end
	end

endmodule

`default_nettype wire

//--- verilog/dac_cmd_sched.sv
`default_nettype none

`include "dac_defines.svh"

module dac_cmd_sched (
	input wire ps_clk,
	input wire ps_rst,
	input wire halt_i,
	input wire run_rand_i,
	input wire run_trig_i,
	input wire dac_pkg::sample_t seed_i,
	input wire dac_pkg::scale_t scale_i,
	input wire dac_pkg::burst_t burst_i,
	input wire credit_ret_i,
	output logic cmd_valid_o,
	output dac_pkg::dac_cmd_t cmd_o,
	output logic idle_o
);
	import dac_pkg::*;

	logic pend_halt;
	logic pend_rand;
	logic pend_trig;
	logic pend_cfg;
	sample_t seed_q;
	scale_t scale_q;
	burst_t burst_q;
	credit_t credits;
	logic cfg_change;
	logic any_pend;
	logic send;
	opcode_t sel_op;

	// Scale or burst moved since last cycle
	assign cfg_change = (scale_i != scale_q) || (burst_i != burst_q);
	assign any_pend = pend_halt || pend_rand || pend_trig || pend_cfg;
	assign send = (credits != '0) && any_pend;

	always_comb begin
		if (pend_halt) begin
			sel_op = OP_HALT;
		end else if (pend_rand) begin
			sel_op = OP_RAND;
		end else if (pend_trig) begin
			sel_op = OP_TRIG;
		end else begin
			sel_op = OP_CFG;
		end
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			pend_halt <= 1'b0;
			pend_rand <= 1'b0;
			pend_trig <= 1'b0;
			pend_cfg <= 1'b0;
			scale_q <= '0;
			burst_q <= burst_t'(1);
			credits <= credit_t'(`CMDQ_DEPTH);
			cmd_valid_o <= 1'b0;
		end else begin
			scale_q <= scale_i;
			burst_q <= burst_i;
			credits <= credits - credit_t'(send) + credit_t'(credit_ret_i);
			cmd_valid_o <= send;
			// A new pulse of the same kind merges with the pending one
			pend_halt <= (pend_halt && !(send && sel_op == OP_HALT)) || halt_i;
			pend_rand <= (pend_rand && !(send && sel_op == OP_RAND)) || run_rand_i;
			pend_trig <= (pend_trig && !(send && sel_op == OP_TRIG)) || run_trig_i;
			pend_cfg <= (pend_cfg && !(send && sel_op == OP_CFG)) || cfg_change;
		end
	end

	always_ff @(posedge ps_clk) begin
		if (run_rand_i) begin
			seed_q <= seed_i; // Latest seed wins on merge
		end
		if (send) begin
			cmd_o.op <= sel_op;
			cmd_o.seed <= seed_q;
			cmd_o.scale <= scale_q;
			cmd_o.burst <= burst_q;
		end
	end

	// Idle only with nothing latched and every credit home
	assign idle_o = !any_pend && !cfg_change && (credits == credit_t'(`CMDQ_DEPTH));

endmodule

`default_nettype wire

//--- verilog/dac_defines.svh
`ifndef DAC_DEFINES_SVH
`define DAC_DEFINES_SVH

// Sample and batch geometry
`define SAMPLE_W 16
`define BATCH_SIZE 4

// Right-shift amount carried with every batch
`define SCALE_W 4

// Burst length in batches
`define BURST_W 8

// Command queue entries, also the credit count at reset
`define CMDQ_DEPTH 4

`endif

//--- verilog/dac_path_top.sv
`default_nettype none

module dac_path_top (
	input wire ps_clk,
	input wire ps_rst,
	input wire halt_i,
	input wire run_rand_i,
	input wire run_trig_i,
	input wire dac_pkg::sample_t seed_i,
	input wire dac_pkg::scale_t scale_i,
	input wire dac_pkg::burst_t burst_i,
	input wire dac_rdy_i,
	output dac_pkg::batch_t batch_o,
	output logic batch_valid_o,
	output logic sched_idle_o
);
	import dac_pkg::*;

	logic cmd_valid;
	dac_cmd_t cmd;
	logic credit_ret;
	logic head_valid;
	dac_cmd_t head;
	logic pop;
	logic gen_valid;
	batch_word_t gen_word;
	logic sched_idle;
	logic gen_busy;

	dac_cmd_sched sched_inst (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.halt_i(halt_i), .run_rand_i(run_rand_i), .run_trig_i(run_trig_i),
		.seed_i(seed_i), .scale_i(scale_i), .burst_i(burst_i),
		.credit_ret_i(credit_ret),
		.cmd_valid_o(cmd_valid), .cmd_o(cmd), .idle_o(sched_idle)
	);

	dac_cmd_queue queue_inst (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.push_i(cmd_valid), .cmd_i(cmd), .pop_i(pop),
		.head_valid_o(head_valid), .head_o(head), .credit_ret_o(credit_ret)
	);

	dac_sample_gen gen_inst (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.head_valid_i(head_valid), .head_i(head), .dac_rdy_i(dac_rdy_i),
		.pop_o(pop), .gen_valid_o(gen_valid), .gen_word_o(gen_word), .busy_o(gen_busy)
	);

	dac_batch_scale scale_inst (
		.ps_clk(ps_clk), .ps_rst(ps_rst),
		.gen_valid_i(gen_valid), .gen_word_i(gen_word),
		.batch_o(batch_o), .batch_valid_o(batch_valid_o)
	);

	// Queue occupancy shows up as outstanding credits in the scheduler
	assign sched_idle_o = sched_idle && !gen_busy;

endmodule

`default_nettype wire

//--- verilog/dac_pkg.sv
`default_nettype none

`include "dac_defines.svh"

package dac_pkg;

	typedef logic [`SAMPLE_W-1:0] sample_t;
	typedef logic [`BATCH_SIZE*`SAMPLE_W-1:0] batch_t; // Lane 0 in low bits
	typedef logic [`SCALE_W-1:0] scale_t;
	typedef logic [`BURST_W-1:0] burst_t;
	typedef logic [1:0] opcode_t;
	typedef logic [$clog2(`CMDQ_DEPTH+1)-1:0] credit_t;

	localparam opcode_t OP_CFG = 2'd0;
	localparam opcode_t OP_TRIG = 2'd1;
	localparam opcode_t OP_RAND = 2'd2;
	localparam opcode_t OP_HALT = 2'd3;

	typedef struct packed {
		opcode_t op;
		sample_t seed;
		scale_t scale;
		burst_t burst;
	} dac_cmd_t;

	typedef struct packed {
		batch_t data;
		scale_t scale; // Applied by the scaler
	} batch_word_t;

endpackage

`default_nettype wire

//--- verilog/dac_sample_gen.sv
`default_nettype none

`include "dac_defines.svh"

module dac_sample_gen (
	input wire ps_clk,
	input wire ps_rst,
	input wire head_valid_i,
	input wire dac_pkg::dac_cmd_t head_i,
	input wire dac_rdy_i,
	output logic pop_o,
	output logic gen_valid_o,
	output dac_pkg::batch_word_t gen_word_o,
	output logic busy_o
);
	import dac_pkg::*;

	typedef enum logic [1:0] {GEN_IDLE, GEN_TRIG, GEN_RAND} gen_state_e;

	gen_state_e state;
	scale_t scale_q;
	burst_t burst_q;
	burst_t cnt; // Batches issued in this burst
	sample_t lfsr_q;
	sample_t lfsr_chain [`BATCH_SIZE];
	logic halt_now;

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic sample_t lfsr_step(input sample_t s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	assign busy_o = (state != GEN_IDLE);
	assign halt_now = busy_o && head_valid_i && (head_i.op == OP_HALT);
	// While running only a halt is taken off the queue
	assign pop_o = head_valid_i && ((state == GEN_IDLE) || (head_i.op == OP_HALT));
	assign gen_valid_o = busy_o && dac_rdy_i && !halt_now;

	always_comb begin
		lfsr_chain[0] = lfsr_step(lfsr_q);
		for (int k = 1; k < `BATCH_SIZE; k++) begin
			lfsr_chain[k] = lfsr_step(lfsr_chain[k-1]);
		end
		for (int k = 0; k < `BATCH_SIZE; k++) begin
			if (state == GEN_RAND) begin
				gen_word_o.data[k*`SAMPLE_W +: `SAMPLE_W] = lfsr_chain[k];
			end else begin
				gen_word_o.data[k*`SAMPLE_W +: `SAMPLE_W] =
					sample_t'(sample_t'(cnt) * `BATCH_SIZE + k);
			end
		end
		gen_word_o.scale = scale_q;
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			state <= GEN_IDLE;
			scale_q <= '0;
			burst_q <= burst_t'(1);
			cnt <= '0;
			lfsr_q <= sample_t'(1);
		end else begin
			unique case (state)
				GEN_IDLE: begin
					if (pop_o && head_i.op != OP_HALT) begin
						scale_q <= head_i.scale;
						burst_q <= head_i.burst;
						cnt <= '0;
						lfsr_q <= (head_i.seed == '0) ? sample_t'(1) : head_i.seed;
						if (head_i.burst != '0) begin // Empty burst stays idle
							if (head_i.op == OP_TRIG) begin
								state <= GEN_TRIG;
							end else if (head_i.op == OP_RAND) begin
								state <= GEN_RAND;
							end
						end
					end
				end
				GEN_TRIG, GEN_RAND: begin
					if (halt_now) begin
						state <= GEN_IDLE;
					end else if (gen_valid_o) begin
						cnt <= cnt + 1'b1;
						lfsr_q <= lfsr_chain[`BATCH_SIZE-1];
						if (cnt == burst_t'(burst_q - 1'b1)) begin
							state <= GEN_IDLE; // Last batch of the burst
						end
					end
				end
				default: state <= GEN_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire
